//--- files.f
hw/csr_pkg.sv
hw/csr_access.sv
hw/csr_counters.sv
hw/csr_trap.sv
hw/csr_top.sv
sim/csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/csr_tb.sv
module csr_tb import csr_pkg::*; ();

    // Phase lengths in cycles, upper bounds
    localparam int RESET_LEN      = 6;
    localparam int RW_LEN         = 24;
    localparam int COUNTER_LEN    = 64;
    localparam int EXCEPTION_LEN  = 10;
    localparam int INTERRUPT_LEN  = 16;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_LEN + RW_LEN + COUNTER_LEN + EXCEPTION_LEN + INTERRUPT_LEN);

    // Bit order is illegal, misaligned, breakpoint, external
    localparam csr_hw_updt_t NO_EVENT      = 4'b0000;
    localparam csr_hw_updt_t EXT_EVENT     = 4'b0001;
    localparam csr_hw_updt_t BRK_MIS_EVENT = 4'b0110;

    logic         clk;
    logic         rst_n;
    csr_inst_t    inst;
    csr_hw_updt_t hw_updt;
    logic [31:0]  pc;
    logic         instr_retired;
    logic [31:0]  read_data;
    logic [31:0]  mepc;
    logic         trap_taken;
    logic [31:0]  trap_vector;

    // Expected outputs, driven together with the stimulus
    logic         chk_rd;
    logic         exp_trap;
    logic [31:0]  exp_rd;
    logic [31:0]  exp_mepc;
    logic [31:0]  exp_vec;
    logic [31:0]  ref_csr [4096];
    int           err_read = 0;
    int           err_trap = 0;
    int           err_mepc = 0;
    int           err_vec = 0;
    int           cycle_cnt = 0;

    csr_top #(.HART_ID(5)) DUT (
        .clk(clk), .rst_n(rst_n), .inst(inst), .hw_updt(hw_updt), .pc(pc),
        .instr_retired(instr_retired), .read_data(read_data), .mepc(mepc),
        .trap_taken(trap_taken), .trap_vector(trap_vector)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // ====================
    // Checkers
    // ====================
    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        chk_rd |-> read_data == exp_rd)
        else begin
            err_read = err_read + 1;
            $display("ERR read_data expected %h got %h", $sampled(exp_rd), $sampled(read_data));
        end

    a_trap_taken: assert property (@(posedge clk) disable iff (!rst_n)
        trap_taken == exp_trap)
        else begin
            err_trap = err_trap + 1;
            $display("ERR trap_taken expected %h got %h", $sampled(exp_trap),
                     $sampled(trap_taken));
        end

    a_mepc: assert property (@(posedge clk) disable iff (!rst_n)
        chk_rd |-> mepc == exp_mepc)
        else begin
            err_mepc = err_mepc + 1;
            $display("ERR mepc expected %h got %h", $sampled(exp_mepc), $sampled(mepc));
        end

    a_trap_vector: assert property (@(posedge clk) disable iff (!rst_n)
        chk_rd |-> trap_vector == exp_vec)
        else begin
            err_vec = err_vec + 1;
            $display("ERR trap_vector expected %h got %h", $sampled(exp_vec),
                     $sampled(trap_vector));
        end

    // ====================
    // Stimulus helpers
    // ====================
    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] old,
                                             input logic [31:0] data);
        case (op)
            CSR_OP_SET:   return old | data;
            CSR_OP_CLEAR: return old & ~data;
            default:      return data;
        endcase
    endfunction

    // Next edge, all inputs back to idle
    task automatic next_cycle();
        @(posedge clk);
        inst          <= '0;
        hw_updt       <= '0;
        instr_retired <= 1'b0;
        chk_rd        <= 1'b0;
        exp_trap      <= 1'b0;
    endtask

    task automatic expect_outputs(input logic [31:0] rd);
        chk_rd   <= 1'b1;
        exp_rd   <= rd;
        exp_mepc <= ref_csr[CSR_MEPC];
        exp_vec  <= ref_csr[CSR_MTVEC] & ~32'd3;
    endtask

    task automatic write_csr(input logic [1:0] op, input logic [11:0] addr,
                             input logic [31:0] data);
        next_cycle();
        inst <= '{wren: 1'b1, rden: 1'b0, op: op, addr: addr, data: data};
        ref_csr[addr] = apply_op(op, ref_csr[addr], data);
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [31:0] expected);
        next_cycle();
        inst <= '{wren: 1'b0, rden: 1'b1, op: 2'b00, addr: addr, data: 32'd0};
        expect_outputs(expected);
    endtask

    // A cause of zero means no trap is expected
    task automatic raise_trap(input csr_hw_updt_t ev, input logic wren, input logic rden,
                              input logic [11:0] addr, input logic [31:0] exp_cause);
        logic [31:0] trap_pc;
        trap_pc = $urandom & 32'hFFFF_FFFC;
        next_cycle();
        expect_outputs(32'd0);
        hw_updt  <= ev;
        inst     <= '{wren: wren, rden: rden, op: CSR_OP_WRITE, addr: addr, data: $urandom};
        pc       <= trap_pc;
        exp_trap <= (exp_cause != 32'd0);
        if (exp_cause != 32'd0) begin
            ref_csr[CSR_MEPC]                  = trap_pc;
            ref_csr[CSR_MCAUSE]                = exp_cause;
            ref_csr[CSR_MSTATUS][MSTATUS_MPIE] = ref_csr[CSR_MSTATUS][MSTATUS_MIE];
            ref_csr[CSR_MSTATUS][MSTATUS_MIE]  = 1'b0;
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [31:0] x;
        int unsigned k1;
        int unsigned k2;
        int unsigned n;
        logic [11:0] rw_addr [3];
        void'($urandom(51505));
        rst_n         = 1'b0;
        inst          = '0;
        hw_updt       = '0;
        pc            = '0;
        instr_retired = 1'b0;
        chk_rd        = 1'b0;
        exp_trap      = 1'b0;
        exp_rd        = '0;
        exp_mepc      = '0;
        exp_vec       = '0;
        ref_csr       = '{default: '0};
        ref_csr[CSR_SCRATCH] = 32'h1001;
        rw_addr       = '{CSR_SCRATCH, CSR_MSCRATCH, CSR_MTVAL};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        read_csr(CSR_SCRATCH, 32'h1001);
        read_csr(CSR_MCAUSE, 32'd0);

        // Write, set and clear on each plain register
        foreach (rw_addr[i]) begin
            for (int op = 1; op < 4; op++) begin
                write_csr(2'(op), rw_addr[i], $urandom);
                read_csr(rw_addr[i], ref_csr[rw_addr[i]]);
            end
        end
        read_csr(CSR_MHARTID, 32'd5);
        raise_trap(NO_EVENT, 1'b0, 1'b1, 12'h7FF, CAUSE_ILLEGAL_INSTR);

        // mcycle from a written start value
        x = $urandom;
        write_csr(CSR_OP_WRITE, CSR_MCYCLE, x);
        k1 = $urandom % 16 + 1;
        repeat (k1) next_cycle();
        read_csr(CSR_MCYCLE, x + k1);
        k2 = $urandom % 16 + 2;
        repeat (k2 - 1) next_cycle();
        read_csr(CSR_MCYCLE, x + k1 + k2);

        // Inhibited mcycle holds still
        write_csr(CSR_OP_SET, CSR_MCOUNTINHIBIT, 32'd1);
        x = $urandom;
        write_csr(CSR_OP_WRITE, CSR_MCYCLE, x);
        read_csr(CSR_MCYCLE, x);
        repeat (8) next_cycle();
        read_csr(CSR_MCYCLE, x);
        write_csr(CSR_OP_CLEAR, CSR_MCOUNTINHIBIT, 32'd1);

        x = $urandom;
        write_csr(CSR_OP_WRITE, CSR_MINSTRET, x);
        n = $urandom % 8 + 1;
        repeat (n) begin
            next_cycle();
            instr_retired <= 1'b1;
        end
        read_csr(CSR_MINSTRET, x + n);

        // Breakpoint outranks misaligned
        write_csr(CSR_OP_WRITE, CSR_MTVEC, $urandom);
        raise_trap(BRK_MIS_EVENT, 1'b0, 1'b0, CSR_MSTATUS, CAUSE_BREAKPOINT);
        read_csr(CSR_MCAUSE, CAUSE_BREAKPOINT);
        read_csr(CSR_MEPC, ref_csr[CSR_MEPC]);
        raise_trap(NO_EVENT, 1'b1, 1'b0, CSR_MVENDORID, CAUSE_ILLEGAL_INSTR);
        read_csr(CSR_MVENDORID, 32'd0);
        read_csr(CSR_MCAUSE, CAUSE_ILLEGAL_INSTR);

        write_csr(CSR_OP_SET, CSR_MSTATUS, 32'd1 << MSTATUS_MIE);
        write_csr(CSR_OP_SET, CSR_MIE, 32'd1 << MIE_MEIE);
        raise_trap(EXT_EVENT, 1'b0, 1'b0, CSR_MSTATUS, CAUSE_EXT_INT);
        read_csr(CSR_MCAUSE, CAUSE_EXT_INT);
        read_csr(CSR_MSTATUS, ref_csr[CSR_MSTATUS]);

        // Timer fires as soon as MIE comes back
        write_csr(CSR_OP_WRITE, CSR_MCYCLE, 32'd1000);
        write_csr(CSR_OP_WRITE, CSR_MTIMECMP, 32'd500);
        write_csr(CSR_OP_SET, CSR_MIE, 32'd1 << MIE_MTIE);
        write_csr(CSR_OP_SET, CSR_MSTATUS, 32'd1 << MSTATUS_MIE);
        raise_trap(NO_EVENT, 1'b0, 1'b0, CSR_MSTATUS, CAUSE_TIMER_INT);
        read_csr(CSR_MCAUSE, CAUSE_TIMER_INT);
        raise_trap(EXT_EVENT, 1'b0, 1'b0, CSR_MSTATUS, 32'd0);
        read_csr(CSR_MSTATUS, ref_csr[CSR_MSTATUS]);
        next_cycle();
        next_cycle();

        $display("Error counts: read_data %0d, trap_taken %0d, mepc %0d, trap_vector %0d",
                 err_read, err_trap, err_mepc, err_vec);
        if (err_read + err_trap + err_mepc + err_vec == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- hw/csr_top.sv
module csr_top import csr_pkg::*; #(
    parameter int unsigned HART_ID = 0
) (
    input  logic         clk,
    input  logic         rst_n,
    input  csr_inst_t    inst,
    input  csr_hw_updt_t hw_updt,
    input  logic [31:0]  pc,
    input  logic         instr_retired,
    output logic [31:0]  read_data,
    output logic [31:0]  mepc,
    output logic         trap_taken,
    output logic [31:0]  trap_vector
);

    csr_wr_t        wr;
    csr_cnt_view_t  cnt_view;
    csr_trap_view_t trap_view;
    logic [31:0]    mcountinhibit;
    logic           illegal_csr;
    logic           timer_pending;

    csr_access #(.HART_ID(HART_ID)) u_access (
        .clk(clk), .rst_n(rst_n), .inst(inst), .cnt_view(cnt_view),
        .trap_view(trap_view), .read_data(read_data), .wr(wr),
        .mcountinhibit(mcountinhibit), .illegal_csr(illegal_csr)
    );

    csr_counters u_counters (
        .clk(clk), .rst_n(rst_n), .instr_retired(instr_retired), .wr(wr),
        .mcountinhibit(mcountinhibit), .cnt_view(cnt_view), .timer_pending(timer_pending)
    );

    csr_trap u_trap (
        .clk(clk), .rst_n(rst_n), .wr(wr), .hw_updt(hw_updt),
        .illegal_csr(illegal_csr), .timer_pending(timer_pending), .pc(pc),
        .trap_view(trap_view), .trap_taken(trap_taken),
        .trap_vector(trap_vector), .mepc(mepc)
    );

endmodule

//--- hw/csr_trap.sv
module csr_trap import csr_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  csr_wr_t        wr,
    input  csr_hw_updt_t   hw_updt,
    input  logic           illegal_csr,
    input  logic           timer_pending,
    input  logic [31:0]    pc,
    output csr_trap_view_t trap_view,
    output logic           trap_taken,
    output logic [31:0]    trap_vector,
    output logic [31:0]    mepc
);

    logic [31:0] mstatus;
    logic [31:0] mie;
    logic [31:0] mtvec;
    logic [31:0] mepc_q;
    logic [31:0] mcause;

    logic        ext_int;
    logic        timer_int;
    logic        int_trap;
    logic [31:0] cause;
    logic [31:0] trap_mstatus;

    // ====================
    // Cause resolution
    // ====================
    assign ext_int   = hw_updt.external_interrupt && mstatus[MSTATUS_MIE] && mie[MIE_MEIE];
    assign timer_int = timer_pending && mstatus[MSTATUS_MIE] && mie[MIE_MTIE];
    assign int_trap  = ext_int || timer_int;

    // Fixed priority, interrupts first
    always_comb begin
        trap_taken = 1'b1;
        cause      = '0;
        if (ext_int) begin
            cause = CAUSE_EXT_INT;
        end else if (timer_int) begin
            cause = CAUSE_TIMER_INT;
        end else if (hw_updt.breakpoint) begin
            cause = CAUSE_BREAKPOINT;
        end else if (illegal_csr || hw_updt.illegal_instruction) begin
            cause = CAUSE_ILLEGAL_INSTR;
        end else if (hw_updt.misaligned_access) begin
            cause = CAUSE_MISALIGNED;
        end else begin
            trap_taken = 1'b0;
        end
    end

    // MIE stacked into MPIE, then cleared
    always_comb begin
        trap_mstatus               = mstatus;
        trap_mstatus[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
        trap_mstatus[MSTATUS_MIE]  = 1'b0;
    end

    // ====================
    // Trap registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mepc_q  <= '0;
            mcause  <= '0;
        end else begin
            if (wr.en) begin
                case (wr.addr)
                    CSR_MSTATUS: mstatus <= wr.value;
                    CSR_MIE:     mie     <= wr.value;
                    CSR_MTVEC:   mtvec   <= wr.value;
                    CSR_MEPC:    mepc_q  <= wr.value;
                    CSR_MCAUSE:  mcause  <= wr.value;
                    default: ;
                endcase
            end
            // Placed last so a trap wins over the software write
            if (trap_taken) begin
                mstatus <= trap_mstatus;
                mepc_q  <= pc;
                mcause  <= cause;
            end
        end
    end

    // Direct mode only
    assign trap_vector = {mtvec[31:2], 2'b00};
    assign mepc        = mepc_q;
    assign trap_view   = '{mstatus: mstatus, mie: mie, mtvec: mtvec,
                           mepc: mepc_q, mcause: mcause};

    // Taking an interrupt masks further ones
    a_no_back_to_back_int: assert property (@(posedge clk) disable iff (!rst_n)
        int_trap |=> !int_trap);

endmodule

//--- hw/csr_counters.sv
module csr_counters import csr_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          instr_retired,
    input  csr_wr_t       wr,
    input  logic [31:0]   mcountinhibit,
    output csr_cnt_view_t cnt_view,
    output logic          timer_pending
);

    // Index 0 is mcycle, index 1 is minstret
    logic [1:0][31:0] cnt_lo;
    logic [1:0][31:0] cnt_hi;
    logic [1:0][32:0] lo_sum;
    logic [1:0]       cnt_inc;
    logic [1:0]       wr_lo;
    logic [1:0]       wr_hi;
    logic [31:0]      mtimecmp;

    assign cnt_inc[0] = !mcountinhibit[0];
    assign cnt_inc[1] = instr_retired && !mcountinhibit[2];

    assign wr_lo[0] = wr.en && (wr.addr == CSR_MCYCLE);
    assign wr_hi[0] = wr.en && (wr.addr == CSR_MCYCLEH);
    assign wr_lo[1] = wr.en && (wr.addr == CSR_MINSTRET);
    assign wr_hi[1] = wr.en && (wr.addr == CSR_MINSTRETH);

    // Low half plus increment, bit 32 is the carry into the high half
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lo_sum[i] = {1'b0, cnt_lo[i]} + 33'(cnt_inc[i]);
        end
    end

    // ====================
    // Counter registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_lo   <= '0;
            cnt_hi   <= '0;
            mtimecmp <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // Software write beats the increment
                if (wr_lo[i]) begin
                    cnt_lo[i] <= wr.value;
                end else begin
                    cnt_lo[i] <= lo_sum[i][31:0];
                end
                if (wr_hi[i]) begin
                    cnt_hi[i] <= wr.value;
                end else if (!wr_lo[i]) begin
                    cnt_hi[i] <= cnt_hi[i] + 32'(lo_sum[i][32]);
                end
            end
            if (wr.en && (wr.addr == CSR_MTIMECMP)) begin
                mtimecmp <= wr.value;
            end
        end
    end

    assign cnt_view = '{mcycle:   {cnt_hi[0], cnt_lo[0]},
                        minstret: {cnt_hi[1], cnt_lo[1]},
                        mtimecmp: mtimecmp};

    // Zero compare value keeps the timer quiet
    assign timer_pending = (mtimecmp != 32'd0) && (cnt_lo[0] >= mtimecmp);

    a_mcycle_step: assert property (@(posedge clk) disable iff (!rst_n)
        (cnt_inc[0] && !wr_lo[0] && !wr_hi[0])
        |=> cnt_view.mcycle == $past(cnt_view.mcycle) + 64'd1);

endmodule

//--- hw/csr_access.sv
module csr_access import csr_pkg::*; #(
    parameter int unsigned HART_ID = 0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  csr_inst_t      inst,
    input  csr_cnt_view_t  cnt_view,
    input  csr_trap_view_t trap_view,
    output logic [31:0]    read_data,
    output csr_wr_t        wr,
    output logic [31:0]    mcountinhibit,
    output logic           illegal_csr
);

    logic [31:0] scratch;
    logic [31:0] mscratch;
    logic [31:0] misa;
    logic [31:0] medeleg;
    logic [31:0] mideleg;
    logic [31:0] mtval;
    logic [31:0] mip;
    logic [31:0] mtinst;
    logic [31:0] mtval2;

    logic [31:0] cur_value;
    logic [31:0] new_value;
    logic        known;
    logic        read_only;

    // ====================
    // Read multiplexer
    // ====================
    // Identity registers read as zero except mhartid
    always_comb begin
        cur_value = '0;
        known     = 1'b1;
        read_only = 1'b0;
        case (inst.addr)
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MCONFIGPTR: read_only = 1'b1;
            CSR_MHARTID: begin
                cur_value = 32'(HART_ID);
                read_only = 1'b1;
            end
            CSR_SCRATCH:       cur_value = scratch;
            CSR_MSCRATCH:      cur_value = mscratch;
            CSR_MISA:          cur_value = misa;
            CSR_MEDELEG:       cur_value = medeleg;
            CSR_MIDELEG:       cur_value = mideleg;
            CSR_MTVAL:         cur_value = mtval;
            CSR_MIP:           cur_value = mip;
            CSR_MCOUNTINHIBIT: cur_value = mcountinhibit;
            CSR_MTINST:        cur_value = mtinst;
            CSR_MTVAL2:        cur_value = mtval2;
            CSR_MCYCLE:        cur_value = cnt_view.mcycle[31:0];
            CSR_MCYCLEH:       cur_value = cnt_view.mcycle[63:32];
            CSR_MINSTRET:      cur_value = cnt_view.minstret[31:0];
            CSR_MINSTRETH:     cur_value = cnt_view.minstret[63:32];
            CSR_MTIMECMP:      cur_value = cnt_view.mtimecmp;
            CSR_MSTATUS:       cur_value = trap_view.mstatus;
            CSR_MIE:           cur_value = trap_view.mie;
            CSR_MTVEC:         cur_value = trap_view.mtvec;
            CSR_MEPC:          cur_value = trap_view.mepc;
            CSR_MCAUSE:        cur_value = trap_view.mcause;
            default:           known = 1'b0;
        endcase
    end

    assign read_data = inst.rden ? cur_value : 32'd0;

    // Merge set and clear against the current value
    always_comb begin
        case (inst.op)
            CSR_OP_WRITE: new_value = inst.data;
            CSR_OP_SET:   new_value = cur_value | inst.data;
            CSR_OP_CLEAR: new_value = cur_value & ~inst.data;
            default:      new_value = cur_value;
        endcase
    end

    assign wr = '{en: inst.wren && known && !read_only, addr: inst.addr, value: new_value};

    assign illegal_csr = (inst.wren && read_only) || ((inst.wren || inst.rden) && !known);

    // ====================
    // Plain registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch       <= 32'h1001;
            mscratch      <= '0;
            misa          <= '0;
            medeleg       <= '0;
            mideleg       <= '0;
            mtval         <= '0;
            mip           <= '0;
            mcountinhibit <= '0;
            mtinst        <= '0;
            mtval2        <= '0;
        end else if (wr.en) begin
            case (wr.addr)
                CSR_SCRATCH:       scratch       <= wr.value;
                CSR_MSCRATCH:      mscratch      <= wr.value;
                CSR_MISA:          misa          <= wr.value;
                CSR_MEDELEG:       medeleg       <= wr.value;
                CSR_MIDELEG:       mideleg       <= wr.value;
                CSR_MTVAL:         mtval         <= wr.value;
                CSR_MIP:           mip           <= wr.value;
                CSR_MCOUNTINHIBIT: mcountinhibit <= wr.value;
                CSR_MTINST:        mtinst        <= wr.value;
                CSR_MTVAL2:        mtval2        <= wr.value;
                default: ;
            endcase
        end
    end

    // A write from the core always names a real operation
    a_wren_has_op: assert property (@(posedge clk) disable iff (!rst_n)
        inst.wren |-> inst.op != 2'b00);

endmodule

//--- hw/csr_pkg.sv
package csr_pkg;

    // ====================
    // Core side structs
    // ====================

    // One CSR access per cycle
    typedef struct packed {
        logic        wren;
        logic        rden;
        logic [1:0]  op;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_inst_t;

    // Hardware events raised by the pipeline
    typedef struct packed {
        logic illegal_instruction;
        logic misaligned_access;
        logic breakpoint;
        logic external_interrupt;
    } csr_hw_updt_t;

    // Write after set or clear has been merged
    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] value;
    } csr_wr_t;

    typedef struct packed {
        logic [63:0] mcycle;
        logic [63:0] minstret;
        logic [31:0] mtimecmp;
    } csr_cnt_view_t;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [31:0] mcause;
    } csr_trap_view_t;

    // ====================
    // Addresses
    // ====================
    localparam logic [11:0] CSR_MVENDORID     = 12'hF11;
    localparam logic [11:0] CSR_MARCHID       = 12'hF12;
    localparam logic [11:0] CSR_MIMPID        = 12'hF13;
    localparam logic [11:0] CSR_MHARTID       = 12'hF14;
    localparam logic [11:0] CSR_MCONFIGPTR    = 12'hF15;
    localparam logic [11:0] CSR_MSTATUS       = 12'h300;
    localparam logic [11:0] CSR_MISA          = 12'h301;
    localparam logic [11:0] CSR_MEDELEG       = 12'h302;
    localparam logic [11:0] CSR_MIDELEG       = 12'h303;
    localparam logic [11:0] CSR_MIE           = 12'h304;
    localparam logic [11:0] CSR_MTVEC         = 12'h305;
    localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
    localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
    localparam logic [11:0] CSR_MEPC          = 12'h341;
    localparam logic [11:0] CSR_MCAUSE        = 12'h342;
    localparam logic [11:0] CSR_MTVAL         = 12'h343;
    localparam logic [11:0] CSR_MIP           = 12'h344;
    localparam logic [11:0] CSR_MTINST        = 12'h34A;
    localparam logic [11:0] CSR_MTVAL2        = 12'h34B;
    localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET      = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH       = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH     = 12'hB82;
    // Custom machine range
    localparam logic [11:0] CSR_MTIMECMP      = 12'h7C0;
    localparam logic [11:0] CSR_SCRATCH       = 12'h800;

    localparam logic [1:0] CSR_OP_WRITE = 2'b01;
    localparam logic [1:0] CSR_OP_SET   = 2'b10;
    localparam logic [1:0] CSR_OP_CLEAR = 2'b11;

    // ====================
    // Causes and bit positions
    // ====================
    localparam logic [31:0] CAUSE_ILLEGAL_INSTR = 32'h0000_0002;
    localparam logic [31:0] CAUSE_BREAKPOINT    = 32'h0000_0003;
    localparam logic [31:0] CAUSE_MISALIGNED    = 32'h0000_0004;
    localparam logic [31:0] CAUSE_TIMER_INT     = 32'h8000_0007;
    localparam logic [31:0] CAUSE_EXT_INT       = 32'h8000_000B;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MIE_MTIE     = 7;
    localparam int MIE_MEIE     = 11;

endpackage
